// File: merge_cfg_pkg.sv
// Shared widths, buffer kinds and packet types for the merge setup path
// Also holds the sequence index helper used by the filter and assembler

`default_nettype none

package merge_cfg_pkg;

    // ----------------------------------------------------------------------
    // Widths
    // ----------------------------------------------------------------------
    localparam int ADDR_W  = 32;
    localparam int DATA_W  = 32;
    localparam int SHIFT_W = 5;

    // Which buffer a memory response belongs to
    typedef enum logic [1:0] {
        BUF_INVALID      = 2'd0,
        BUF_CU_SETUP     = 2'd1,
        BUF_ENGINE_SETUP = 2'd2,
        BUF_OTHER        = 2'd3
    } buffer_kind_e;

    // ----------------------------------------------------------------------
    // Memory response side
    // ----------------------------------------------------------------------
    typedef struct packed {
        buffer_kind_e        kind;
        logic [ADDR_W-1:0]   offset;
        logic [SHIFT_W-1:0]  shift;
        logic [DATA_W-1:0]   data;
    } mem_word_t;

    typedef struct packed {
        logic      valid;
        mem_word_t payload;
    } mem_packet_t;

    // ----------------------------------------------------------------------
    // Merge configuration side
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic [DATA_W-1:0] merge_mask;
        logic [DATA_W-1:0] merge_type;
        logic              mode_buffer;
    } merge_config_t;

    typedef struct packed {
        logic          valid;
        merge_config_t payload;
    } merge_config_packet_t;

    // Offset scaled down to a sequence index
    function automatic logic [ADDR_W-1:0] seq_index(input mem_word_t w);
        return w.offset >> w.shift;
    endfunction

endpackage

`default_nettype wire

// File: sync_fifo.sv
// Synchronous FIFO on a circular buffer with an occupancy count
// Read data and valid are registered one cycle after the read strobe

`timescale 1ns/100ps
`default_nettype none

module sync_fifo #(
    parameter int WIDTH       = 8,
    parameter int DEPTH       = 32,
    parameter int PROG_THRESH = 16
) (
    input  wire logic             ap_clk,
    input  wire logic             areset_csr_index_generator,
    input  wire logic             wr_en,
    input  wire logic [WIDTH-1:0] din,
    input  wire logic             rd_en,
    output logic      [WIDTH-1:0] dout,
    output logic                  valid,
    output logic                  empty,
    output logic                  almost_full
);

    localparam int AW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [CW-1:0]    count;
    logic             full;
    logic             wr_ok;
    logic             rd_ok;

    assign full        = (count == CW'(DEPTH));
    assign empty       = (count == '0);
    assign almost_full = (count >= CW'(PROG_THRESH));
    // Writes into a full buffer and reads from an empty one are ignored
    assign wr_ok       = wr_en & ~full;
    assign rd_ok       = rd_en & ~empty;

    // ----------------------------------------------------------------------
    // Pointers and occupancy
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            valid  <= 1'b0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            valid <= rd_ok;
        end
    end

    // Storage and read register
    always_ff @(posedge ap_clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= din;
        end
        if (rd_ok) begin
            dout <= mem[rd_ptr];
        end
    end

    a_no_write_when_full : assert property (@(posedge ap_clk)
        disable iff (areset_csr_index_generator) !(wr_en && full))
        else $error("sync_fifo: write dropped, FIFO full");

    a_no_read_when_empty : assert property (@(posedge ap_clk)
        disable iff (areset_csr_index_generator) !(rd_en && empty))
        else $error("sync_fifo: read strobe on empty FIFO");

endmodule

`default_nettype wire

// File: setup_word_filter.sv
// Setup word filter
// Registers each memory response and keeps only setup words whose
// sequence index falls inside this engine's window

`timescale 1ns/100ps
`default_nettype none

module setup_word_filter #(
    parameter int SEQ_WIDTH = 16,
    parameter int SEQ_BASE  = 0
) (
    input  wire logic                      ap_clk,
    input  wire logic                      areset_csr_index_generator,
    input  wire merge_cfg_pkg::mem_packet_t response_in,
    output logic                           keep_word,
    output merge_cfg_pkg::mem_word_t       kept_word
);

    localparam logic [merge_cfg_pkg::ADDR_W-1:0] WIN_LO = SEQ_BASE;
    localparam logic [merge_cfg_pkg::ADDR_W-1:0] WIN_HI = SEQ_BASE + SEQ_WIDTH;

    merge_cfg_pkg::mem_packet_t        response_reg;
    logic [merge_cfg_pkg::ADDR_W-1:0]  seq;
    logic                              kind_ok;
    logic                              in_window;

    // ----------------------------------------------------------------------
    // Input register
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        response_reg.payload <= response_in.payload;
        if (areset_csr_index_generator) begin
            response_reg.valid <= 1'b0;
        end else begin
            response_reg.valid <= response_in.valid;
        end
    end

    // Window decision on the registered word
    assign seq       = merge_cfg_pkg::seq_index(response_reg.payload);
    assign kind_ok   = (response_reg.payload.kind == merge_cfg_pkg::BUF_CU_SETUP) ||
                       (response_reg.payload.kind == merge_cfg_pkg::BUF_ENGINE_SETUP);
    assign in_window = (seq >= WIN_LO) && (seq < WIN_HI);

    assign keep_word = response_reg.valid & kind_ok & in_window;
    assign kept_word = response_reg.payload;

endmodule

`default_nettype wire

// File: merge_config_assembler.sv
// Merge configuration assembler
// Drains kept setup words, captures mask, type and mode, and pushes one
// configuration each time every index of the window has been seen

`timescale 1ns/100ps
`default_nettype none

module merge_config_assembler #(
    parameter int SEQ_WIDTH = 16,
    parameter int SEQ_BASE  = 0
) (
    input  wire logic                     ap_clk,
    input  wire logic                     areset_csr_index_generator,
    input  wire logic                     word_empty,
    input  wire logic                     word_valid,
    input  wire merge_cfg_pkg::mem_word_t word,
    input  wire logic                     config_almost_full,
    output logic                          word_pop,
    output logic                          config_push,
    output merge_cfg_pkg::merge_config_t  config_data
);

    logic [merge_cfg_pkg::ADDR_W-1:0] word_seq;
    logic [SEQ_WIDTH-1:0]             hit;
    logic [SEQ_WIDTH-1:0]             seen;
    logic                             all_seen;
    logic                             will_complete;
    logic                             complete;
    logic [merge_cfg_pkg::DATA_W-1:0] merge_mask;
    logic [merge_cfg_pkg::DATA_W-1:0] merge_type;
    logic                             mode_buffer;

    // ----------------------------------------------------------------------
    // Index decode
    // ----------------------------------------------------------------------
    assign word_seq = merge_cfg_pkg::seq_index(word);

    always_comb begin
        for (int i = 0; i < SEQ_WIDTH; i++) begin
            hit[i] = word_valid && (word_seq == merge_cfg_pkg::ADDR_W'(SEQ_BASE + i));
        end
    end

    assign all_seen      = &seen;
    // The word now being recorded finishes the window
    assign will_complete = &(seen | hit);

    // Hold reads from the moment the window closes until the push is done
    assign word_pop = ~word_empty & ~config_almost_full & ~will_complete & ~complete;

    // ----------------------------------------------------------------------
    // Record of seen indices and completion
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            seen     <= '0;
            complete <= 1'b0;
        end else begin
            complete <= all_seen & ~complete;
            if (complete) begin
                seen <= '0;
            end else begin
                seen <= seen | hit;
            end
        end
    end

    // Parameters persist until overwritten
    always_ff @(posedge ap_clk) begin
        if (hit[0]) begin
            merge_mask <= word.data;
        end
        if (hit[1]) begin
            merge_type <= word.data;
        end
        if (hit[2]) begin
            mode_buffer <= word.data[0];
        end
    end

    assign config_push             = complete;
    assign config_data.merge_mask  = merge_mask;
    assign config_data.merge_type  = merge_type;
    assign config_data.mode_buffer = mode_buffer;

    // No word of the next window may still be arriving when the push goes out
    a_push_after_full_window : assert property (@(posedge ap_clk)
        disable iff (areset_csr_index_generator)
        $rose(config_push) |-> $past(all_seen) && !$past(word_valid))
        else $error("merge_config_assembler: push without a complete, settled window");

endmodule

`default_nettype wire

// File: merge_data_configure_memory.sv
// Merge data configure memory, top level
// Filters setup words into a response FIFO, assembles merge configurations
// into an output FIFO, and registers popped configurations to the consumer

`timescale 1ns/100ps
`default_nettype none

module merge_data_configure_memory #(
    parameter int SEQ_WIDTH   = 16,
    parameter int SEQ_BASE    = 0,
    parameter int FIFO_DEPTH  = 32,
    parameter int PROG_THRESH = 16
) (
    input  wire logic                       ap_clk,
    input  wire logic                       areset_csr_index_generator,
    input  wire merge_cfg_pkg::mem_packet_t  response_in,
    input  wire logic                       config_pop,
    output merge_cfg_pkg::merge_config_packet_t config_out
);

    // ----------------------------------------------------------------------
    // Internal signals
    // ----------------------------------------------------------------------
    logic                          keep_word;
    merge_cfg_pkg::mem_word_t      kept_word;
    merge_cfg_pkg::mem_word_t      word_dout;
    logic                          word_valid;
    logic                          word_empty;
    logic                          word_pop;
    logic                          config_push;
    merge_cfg_pkg::merge_config_t  config_data;
    merge_cfg_pkg::merge_config_t  cfg_dout;
    logic                          cfg_valid;
    logic                          cfg_empty;
    logic                          cfg_almost_full;
    logic                          cfg_rd_en;

    setup_word_filter #(
        .SEQ_WIDTH(SEQ_WIDTH),
        .SEQ_BASE (SEQ_BASE)
    ) u_filter (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .response_in               (response_in),
        .keep_word                 (keep_word),
        .kept_word                 (kept_word)
    );

    // Kept words, drained by the assembler
    sync_fifo #(
        .WIDTH      ($bits(merge_cfg_pkg::mem_word_t)),
        .DEPTH      (FIFO_DEPTH),
        .PROG_THRESH(PROG_THRESH)
    ) u_word_fifo (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .wr_en                     (keep_word),
        .din                       (kept_word),
        .rd_en                     (word_pop),
        .dout                      (word_dout),
        .valid                     (word_valid),
        .empty                     (word_empty),
        .almost_full               ()
    );

    merge_config_assembler #(
        .SEQ_WIDTH(SEQ_WIDTH),
        .SEQ_BASE (SEQ_BASE)
    ) u_assembler (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .word_empty                (word_empty),
        .word_valid                (word_valid),
        .word                      (word_dout),
        .config_almost_full        (cfg_almost_full),
        .word_pop                  (word_pop),
        .config_push               (config_push),
        .config_data               (config_data)
    );

    // Pops on an empty FIFO never reach it
    assign cfg_rd_en = config_pop & ~cfg_empty;

    sync_fifo #(
        .WIDTH      ($bits(merge_cfg_pkg::merge_config_t)),
        .DEPTH      (FIFO_DEPTH),
        .PROG_THRESH(PROG_THRESH)
    ) u_config_fifo (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .wr_en                     (config_push),
        .din                       (config_data),
        .rd_en                     (cfg_rd_en),
        .dout                      (cfg_dout),
        .valid                     (cfg_valid),
        .empty                     (cfg_empty),
        .almost_full               (cfg_almost_full)
    );

    // ----------------------------------------------------------------------
    // Output register
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        config_out.payload <= cfg_dout;
        if (areset_csr_index_generator) begin
            config_out.valid <= 1'b0;
        end else begin
            config_out.valid <= cfg_valid;
        end
    end

endmodule

`default_nettype wire

// File: tb_merge_data_configure_memory.sv
// Testbench for the merge data configure memory
// Directed tests drive setup words and pop configurations, checked against
// a model of the last mask, type and mode written

`timescale 1ns/100ps
`default_nettype none

module tb_merge_data_configure_memory;

    localparam int SEQ_WIDTH    = 16;
    localparam int FIFO_DEPTH   = 32;
    localparam int CLK_PERIOD   = 8;
    // Long enough for a full word FIFO to drain
    localparam int DRAIN_CYCLES = 2 * FIFO_DEPTH;
    localparam int POP_TRIES    = 16;
    // The five tests take about 500 cycles; allow five times that
    localparam int WATCHDOG_NS  = 5 * 500 * CLK_PERIOD;

    logic                                ap_clk;
    logic                                areset_csr_index_generator;
    merge_cfg_pkg::mem_packet_t          response_in;
    logic                                config_pop;
    merge_cfg_pkg::merge_config_packet_t config_out;

    logic [31:0]                  lcg_state;
    logic [31:0]                  exp_mask;
    logic [31:0]                  exp_type;
    logic                         exp_mode;
    merge_cfg_pkg::merge_config_t exp_q[$];
    int                           err_count;
    int                           check_count;
    int                           tests_run;
    int                           tests_failed;

    merge_data_configure_memory #(
        .SEQ_WIDTH  (SEQ_WIDTH),
        .SEQ_BASE   (0),
        .FIFO_DEPTH (FIFO_DEPTH),
        .PROG_THRESH(16)
    ) dut (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .response_in               (response_in),
        .config_pop                (config_pop),
        .config_out                (config_out)
    );

    always #(CLK_PERIOD / 2) ap_clk = ~ap_clk;

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog: run still going after %0d ns, stopping", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

    // ----------------------------------------------------------------------
    // Random numbers and reporting
    // ----------------------------------------------------------------------
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic int rand_below(input int n);
        return int'(lcg_next() >> 8) % n;
    endfunction

    task automatic compare_word(input string sig, input logic [31:0] got,
                                input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("ERR %s: got %h expected %h", sig, got, exp);
        end
    endtask

    task automatic note_failure(input string msg);
        err_count++;
        $display("%s", msg);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (err_count != errs_before) begin
            tests_failed++;
            $display("test %s: FAIL, %0d errors", name, err_count - errs_before);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    // ----------------------------------------------------------------------
    // Bus drivers
    // ----------------------------------------------------------------------
    // Offset is the index scaled up by the shift amount
    task automatic send_word(input logic valid, input merge_cfg_pkg::buffer_kind_e kind,
                             input int idx, input int shift, input logic [31:0] data);
        logic [31:0] offset;
        offset = 32'(idx) << shift;
        @(negedge ap_clk);
        response_in.valid         = valid;
        response_in.payload.kind  = kind;
        response_in.payload.offset = offset;
        response_in.payload.shift = 5'(shift);
        response_in.payload.data  = data;
        // Only valid setup words inside the window reach the parameters
        if (valid && (kind == merge_cfg_pkg::BUF_CU_SETUP ||
                      kind == merge_cfg_pkg::BUF_ENGINE_SETUP) && idx < SEQ_WIDTH) begin
            if (idx == 0) exp_mask = data;
            if (idx == 1) exp_type = data;
            if (idx == 2) exp_mode = data[0];
        end
    endtask

    task automatic quiet_bus();
        @(negedge ap_clk);
        response_in.valid = 1'b0;
    endtask

    task automatic snapshot_config();
        exp_q.push_back({exp_mask, exp_type, exp_mode});
    endtask

    // Pop strobe, then config_out is read two edges after it
    task automatic pop_config(output logic got, output merge_cfg_pkg::merge_config_t cfg);
        @(negedge ap_clk);
        config_pop = 1'b1;
        @(negedge ap_clk);
        config_pop = 1'b0;
        @(negedge ap_clk);
        got = config_out.valid;
        cfg = config_out.payload;
    endtask

    task automatic pop_expect();
        logic                         got;
        int                           tries;
        merge_cfg_pkg::merge_config_t cfg;
        merge_cfg_pkg::merge_config_t exp;
        got   = 1'b0;
        tries = 0;
        exp   = exp_q.pop_front();
        while (!got && tries < POP_TRIES) begin
            pop_config(got, cfg);
            tries++;
        end
        check_count++;
        if (!got) begin
            note_failure($sformatf("no configuration came out after %0d pops", tries));
        end else begin
            compare_word("config_out.merge_mask", cfg.merge_mask, exp.merge_mask);
            compare_word("config_out.merge_type", cfg.merge_type, exp.merge_type);
            compare_word("config_out.mode_buffer", 32'(cfg.mode_buffer),
                         32'(exp.mode_buffer));
        end
    endtask

    task automatic pop_none();
        logic                         got;
        merge_cfg_pkg::merge_config_t cfg;
        repeat (DRAIN_CYCLES) @(negedge ap_clk);
        pop_config(got, cfg);
        check_count++;
        if (got) begin
            note_failure("a pop returned a configuration while none should be stored");
        end
    endtask

    // Indices 0 to 15 in order; keep_params rewrites 0 to 2 with held values
    task automatic send_ordered_window(input bit keep_params);
        logic [31:0] data;
        for (int i = 0; i < SEQ_WIDTH; i++) begin
            data = lcg_next();
            if (keep_params && i == 0) data = exp_mask;
            if (keep_params && i == 1) data = exp_type;
            if (keep_params && i == 2) data = {data[31:1], exp_mode};
            send_word(1'b1, (i % 2 == 1) ? merge_cfg_pkg::BUF_ENGINE_SETUP
                                         : merge_cfg_pkg::BUF_CU_SETUP, i, 0, data);
        end
        snapshot_config();
    endtask

    // ----------------------------------------------------------------------
    // Directed tests
    // ----------------------------------------------------------------------
    task automatic test_reset_idle();
        int errs_before;
        errs_before = err_count;
        repeat (8) begin
            @(negedge ap_clk);
            compare_word("config_out.valid", 32'(config_out.valid), 32'd0);
        end
        pop_none();
        finish_test("reset_idle", errs_before);
    endtask

    task automatic test_in_order();
        int errs_before;
        errs_before = err_count;
        send_ordered_window(1'b0);
        quiet_bus();
        pop_expect();
        finish_test("in_order_window", errs_before);
    endtask

    task automatic test_shuffled_repeats();
        int perm [SEQ_WIDTH];
        int errs_before;
        int j;
        int tmp;
        errs_before = err_count;
        for (int i = 0; i < SEQ_WIDTH; i++) perm[i] = i;
        for (int i = SEQ_WIDTH - 1; i > 0; i--) begin
            j       = rand_below(i + 1);
            tmp     = perm[i];
            perm[i] = perm[j];
            perm[j] = tmp;
        end
        for (int i = 0; i < SEQ_WIDTH - 1; i++) begin
            send_word(1'b1, merge_cfg_pkg::BUF_CU_SETUP, perm[i], rand_below(28), lcg_next());
        end
        // Repeats before the last new index stay in this window
        repeat (6) begin
            j = perm[rand_below(SEQ_WIDTH - 1)];
            send_word(1'b1, merge_cfg_pkg::BUF_ENGINE_SETUP, j, rand_below(28), lcg_next());
        end
        for (int k = 0; k < 3; k++) begin
            if (k != perm[SEQ_WIDTH-1]) begin
                send_word(1'b1, merge_cfg_pkg::BUF_CU_SETUP, k, rand_below(28), lcg_next());
            end
        end
        send_word(1'b1, merge_cfg_pkg::BUF_ENGINE_SETUP, perm[SEQ_WIDTH-1], rand_below(28),
                  lcg_next());
        snapshot_config();
        quiet_bus();
        pop_expect();
        pop_none();
        finish_test("shuffled_repeats", errs_before);
    endtask

    task automatic test_filtered_words();
        int errs_before;
        int missing;
        errs_before = err_count;
        missing     = 3 + rand_below(SEQ_WIDTH - 3);
        for (int i = 0; i < SEQ_WIDTH; i++) begin
            if (i != missing) begin
                send_word(1'b1, merge_cfg_pkg::BUF_CU_SETUP, i, rand_below(28), lcg_next());
            end
        end
        // None of these may touch the parameters or close the window
        send_word(1'b1, merge_cfg_pkg::BUF_OTHER, 0, 3, lcg_next());
        send_word(1'b1, merge_cfg_pkg::BUF_OTHER, missing, 1, lcg_next());
        send_word(1'b1, merge_cfg_pkg::BUF_INVALID, 1, 0, lcg_next());
        send_word(1'b1, merge_cfg_pkg::BUF_CU_SETUP, 16, 4, lcg_next());
        send_word(1'b1, merge_cfg_pkg::BUF_ENGINE_SETUP, 23, 2, lcg_next());
        send_word(1'b0, merge_cfg_pkg::BUF_CU_SETUP, missing, 0, lcg_next());
        send_word(1'b0, merge_cfg_pkg::BUF_CU_SETUP, 2, 0, ~exp_mode ? 32'd1 : 32'd0);
        quiet_bus();
        pop_none();
        send_word(1'b1, merge_cfg_pkg::BUF_ENGINE_SETUP, missing, 0, lcg_next());
        snapshot_config();
        quiet_bus();
        pop_expect();
        finish_test("filtered_words", errs_before);
    endtask

    task automatic test_back_to_back();
        int errs_before;
        errs_before = err_count;
        send_ordered_window(1'b0);
        send_ordered_window(1'b0);
        send_ordered_window(1'b1);
        quiet_bus();
        repeat (3) pop_expect();
        pop_none();
        finish_test("back_to_back", errs_before);
    endtask

    initial begin
        ap_clk                     = 1'b0;
        areset_csr_index_generator = 1'b1;
        response_in                = '0;
        config_pop                 = 1'b0;
        lcg_state                  = 32'd95132;
        exp_mask                   = '0;
        exp_type                   = '0;
        exp_mode                   = 1'b0;
        err_count                  = 0;
        check_count                = 0;
        tests_run                  = 0;
        tests_failed               = 0;
        repeat (5) @(posedge ap_clk);
        @(negedge ap_clk);
        areset_csr_index_generator = 1'b0;

        test_reset_idle();
        test_in_order();
        test_shuffled_repeats();
        test_filtered_words();
        test_back_to_back();

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, check_count, err_count);
        if (err_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: merge_data_configure_memory.f
merge_cfg_pkg.sv
sync_fifo.sv
setup_word_filter.sv
merge_config_assembler.sv
merge_data_configure_memory.sv
tb_merge_data_configure_memory.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir
TOP=tb_merge_data_configure_memory

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module "$TOP" --Mdir "$BUILD_DIR" -o sim_tb \
    -f merge_data_configure_memory.f
if [ $? -ne 0 ]; then
    echo "run_sim: Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "run_sim: simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    echo "run_sim: FAIL"
    exit 1
fi

echo "run_sim: PASS"
exit 0
